// File: common/gat_dims_pkg.sv
package gat_dims_pkg;

  // Graph and layer sizes, kept small so simulation stays short
  localparam int NUM_FEATURE_OUT = 4;
  localparam int TOTAL_NODES     = 8;
  localparam int NUM_SUBGRAPHS   = 3;

  // Column index within one feature vector
  localparam int FEAT_IDX_W = $clog2(NUM_FEATURE_OUT);

  // Node index as stored in the subgraph index table
  localparam int NODE_IDX_W = $clog2(TOTAL_NODES);

  // Subgraph counter, one step per start-of-subgraph entry
  localparam int SG_CNT_W = $clog2(NUM_SUBGRAPHS);

  // Index table depth and address
  localparam int IDX_DEPTH  = TOTAL_NODES;
  localparam int IDX_ADDR_W = $clog2(IDX_DEPTH);

  // Layer-1 feature memory, one vector per subgraph
  localparam int FEAT_DEPTH  = NUM_SUBGRAPHS * NUM_FEATURE_OUT;
  localparam int FEAT_ADDR_W = $clog2(FEAT_DEPTH);

  // Layer-2 H-data memory, one row of NUM_FEATURE_OUT words per node
  localparam int H_DEPTH  = TOTAL_NODES * NUM_FEATURE_OUT;
  localparam int H_ADDR_W = $clog2(H_DEPTH);

endpackage

// File: common/gat_mem_pkg.sv
package gat_mem_pkg;

  // Layer-1 output feature, fixed point
  localparam int FEAT_W = 32;

  // Quantized layer-2 value
  localparam int DATA_W = 8;

  // Integer width of the layer-1 result before requantization
  localparam int L1_DATA_W = 10;

  // Upper half-word, then drop the extra layer-1 bits
  localparam int QUANT_SHIFT = FEAT_W / 2 + (L1_DATA_W - DATA_W);

  typedef logic [FEAT_W-1:0] feat_word_t;

  // One subgraph index table entry
  typedef struct packed {
    logic                                sog;
    logic [gat_dims_pkg::NODE_IDX_W-1:0] node_idx;
  } idx_entry_t;

  // One H-data word, value tagged with its column
  typedef struct packed {
    logic [gat_dims_pkg::FEAT_IDX_W-1:0] col;
    logic [DATA_W-1:0]                   val;
  } h_word_t;

endpackage

// File: src/bram_sdp.sv
`timescale 1ns/1ps

module bram_sdp #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = 16,
  localparam int AW    = $clog2(DEPTH)
) (
  input  logic          clk,
  input  logic          wr_en_i,
  input  logic [AW-1:0] wr_addr_i,
  input  T              wr_data_i,
  input  logic [AW-1:0] rd_addr_i,
  output T              rd_data_o
);

  T mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // Registered read, data valid one cycle after the address
  always_ff @(posedge clk) begin
    rd_data_o <= mem[rd_addr_i];
  end

endmodule

// File: subgraph_handler/subgraph_handler.sv
`timescale 1ns/1ps

module subgraph_handler (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 start_i,
  output logic                                 busy_o,
  output logic                                 done_o,
  output logic [gat_dims_pkg::IDX_ADDR_W-1:0]  idx_raddr_o,
  input  gat_mem_pkg::idx_entry_t              idx_rdata_i,
  output logic [gat_dims_pkg::FEAT_ADDR_W-1:0] feat_raddr_o,
  input  gat_mem_pkg::feat_word_t              feat_rdata_i,
  output logic                                 wr_req_o,
  output logic [gat_dims_pkg::H_ADDR_W-1:0]    wr_addr_o,
  output gat_mem_pkg::h_word_t                 wr_data_o
);

  localparam int NFO    = gat_dims_pkg::NUM_FEATURE_OUT;
  localparam int STEP_W = gat_dims_pkg::FEAT_IDX_W + 1;

  typedef enum logic [2:0] {
    S_IDLE,
    S_FETCH,
    S_LOAD,
    S_WRITE,
    S_NEXT
  } state_t;

  state_t                               state_q;
  logic [gat_dims_pkg::IDX_ADDR_W-1:0]  entry_q;
  logic [gat_dims_pkg::SG_CNT_W-1:0]    sg_q;
  logic [STEP_W-1:0]                    step_q;
  logic [gat_dims_pkg::NODE_IDX_W-1:0]  node_q;
  gat_mem_pkg::feat_word_t              feat_q [NFO];
  logic [gat_dims_pkg::FEAT_IDX_W-1:0]  col;
  logic [gat_dims_pkg::FEAT_IDX_W-1:0]  ld_idx;
  logic                                 load_last;
  logic                                 write_last;
  logic                                 entry_last;

  assign col        = step_q[gat_dims_pkg::FEAT_IDX_W-1:0];
  assign ld_idx     = gat_dims_pkg::FEAT_IDX_W'(step_q - 1'b1);
  assign load_last  = (step_q == STEP_W'(NFO));
  assign write_last = (step_q == STEP_W'(NFO - 1));
  assign entry_last = (entry_q == gat_dims_pkg::IDX_ADDR_W'(gat_dims_pkg::TOTAL_NODES - 1));

  // Control path
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      entry_q <= '0;
      sg_q    <= '0;
      step_q  <= '0;
      done_o  <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state_q)
        S_IDLE: begin
          // Start while busy never reaches here, so it is dropped
          if (start_i) begin
            entry_q <= '0;
            sg_q    <= '0;
            state_q <= S_NEXT;
          end
        end
        S_NEXT: begin
          // Index address on the bus, entry lands next cycle
          state_q <= S_FETCH;
        end
        S_FETCH: begin
          step_q  <= '0;
          state_q <= idx_rdata_i.sog ? S_LOAD : S_WRITE;
        end
        S_LOAD: begin
          if (load_last) begin
            step_q  <= '0;
            sg_q    <= sg_q + 1'b1;
            state_q <= S_WRITE;
          end else begin
            step_q <= step_q + 1'b1;
          end
        end
        S_WRITE: begin
          if (write_last) begin
            step_q  <= '0;
            entry_q <= entry_q + 1'b1;
            if (entry_last) begin
              done_o  <= 1'b1;
              state_q <= S_IDLE;
            end else begin
              state_q <= S_NEXT;
            end
          end else begin
            step_q <= step_q + 1'b1;
          end
        end
        default: begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  // Node index of the current entry and the cached feature vector
  always_ff @(posedge clk) begin
    if (state_q == S_FETCH) begin
      node_q <= idx_rdata_i.node_idx;
    end
    // Word k returns one cycle after its address, so step k+1 stores it
    if (state_q == S_LOAD && step_q != '0) begin
      feat_q[ld_idx] <= feat_rdata_i;
    end
  end

  assign busy_o      = (state_q != S_IDLE);
  assign idx_raddr_o = entry_q;

  // Vector base of the current subgraph plus the word offset
  assign feat_raddr_o = gat_dims_pkg::FEAT_ADDR_W'(sg_q * NFO + col);

  // One write per cycle, row node_idx and column k
  assign wr_req_o      = (state_q == S_WRITE);
  assign wr_addr_o     = gat_dims_pkg::H_ADDR_W'(node_q * NFO + col);
  assign wr_data_o.col = col;
  assign wr_data_o.val = gat_mem_pkg::DATA_W'(feat_q[col] >> gat_mem_pkg::QUANT_SHIFT);

endmodule

// File: src/h_bus_arbiter.sv
`timescale 1ns/1ps

module h_bus_arbiter (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              wr_req_i,
  input  logic [gat_dims_pkg::H_ADDR_W-1:0] wr_addr_i,
  input  gat_mem_pkg::h_word_t              wr_data_i,
  input  logic                              rd_req_i,
  input  logic [gat_dims_pkg::H_ADDR_W-1:0] rd_addr_i,
  output logic                              rd_vld_o,
  output gat_mem_pkg::h_word_t              rd_data_o,
  output logic                              mem_we_o,
  output logic [gat_dims_pkg::H_ADDR_W-1:0] mem_addr_o,
  output gat_mem_pkg::h_word_t              mem_wdata_o,
  input  gat_mem_pkg::h_word_t              mem_rdata_i
);

  logic                              pend_q;
  logic [gat_dims_pkg::H_ADDR_W-1:0] pend_addr_q;
  logic                              rd_grant;
  logic                              rd_inflight_q;

  // Handler writes always win, a host read takes any idle cycle
  assign rd_grant = pend_q && !wr_req_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_q        <= 1'b0;
      rd_inflight_q <= 1'b0;
    end else begin
      if (rd_req_i) begin
        pend_q <= 1'b1;
      end else if (rd_grant) begin
        pend_q <= 1'b0;
      end
      rd_inflight_q <= rd_grant;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_req_i) begin
      pend_addr_q <= rd_addr_i;
    end
  end

  assign mem_we_o    = wr_req_i;
  assign mem_addr_o  = wr_req_i ? wr_addr_i : pend_addr_q;
  assign mem_wdata_o = wr_data_i;

  // Memory read data is registered, so it lines up with the in-flight flag
  assign rd_vld_o  = rd_inflight_q;
  assign rd_data_o = mem_rdata_i;

endmodule

// File: src/gat_scatter_top.sv
`timescale 1ns/1ps

module gat_scatter_top (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 start_i,
  output logic                                 busy_o,
  output logic                                 done_o,
  input  logic                                 feat_we_i,
  input  logic [gat_dims_pkg::FEAT_ADDR_W-1:0] feat_waddr_i,
  input  gat_mem_pkg::feat_word_t              feat_wdata_i,
  input  logic                                 idx_we_i,
  input  logic [gat_dims_pkg::IDX_ADDR_W-1:0]  idx_waddr_i,
  input  gat_mem_pkg::idx_entry_t              idx_wdata_i,
  input  logic                                 rd_req_i,
  input  logic [gat_dims_pkg::H_ADDR_W-1:0]    rd_addr_i,
  output logic                                 rd_vld_o,
  output gat_mem_pkg::h_word_t                 rd_data_o
);

  logic [gat_dims_pkg::IDX_ADDR_W-1:0]  idx_raddr;
  gat_mem_pkg::idx_entry_t              idx_rdata;
  logic [gat_dims_pkg::FEAT_ADDR_W-1:0] feat_raddr;
  gat_mem_pkg::feat_word_t              feat_rdata;

  logic                                 wr_req;
  logic [gat_dims_pkg::H_ADDR_W-1:0]    wr_addr;
  gat_mem_pkg::h_word_t                 wr_data;

  logic                                 mem_we;
  logic [gat_dims_pkg::H_ADDR_W-1:0]    mem_addr;
  gat_mem_pkg::h_word_t                 mem_wdata;
  gat_mem_pkg::h_word_t                 mem_rdata;

  // Layer-1 features, loaded by the host
  bram_sdp #(
    .T     (gat_mem_pkg::feat_word_t),
    .DEPTH (gat_dims_pkg::FEAT_DEPTH)
  ) feat_mem_i (
    .clk       (clk),
    .wr_en_i   (feat_we_i),
    .wr_addr_i (feat_waddr_i),
    .wr_data_i (feat_wdata_i),
    .rd_addr_i (feat_raddr),
    .rd_data_o (feat_rdata)
  );

  // Subgraph index table
  bram_sdp #(
    .T     (gat_mem_pkg::idx_entry_t),
    .DEPTH (gat_dims_pkg::IDX_DEPTH)
  ) idx_mem_i (
    .clk       (clk),
    .wr_en_i   (idx_we_i),
    .wr_addr_i (idx_waddr_i),
    .wr_data_i (idx_wdata_i),
    .rd_addr_i (idx_raddr),
    .rd_data_o (idx_rdata)
  );

  // Single-port H-data memory, one address for both directions
  bram_sdp #(
    .T     (gat_mem_pkg::h_word_t),
    .DEPTH (gat_dims_pkg::H_DEPTH)
  ) h_mem_i (
    .clk       (clk),
    .wr_en_i   (mem_we),
    .wr_addr_i (mem_addr),
    .wr_data_i (mem_wdata),
    .rd_addr_i (mem_addr),
    .rd_data_o (mem_rdata)
  );

  subgraph_handler subgraph_handler_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (start_i),
    .busy_o       (busy_o),
    .done_o       (done_o),
    .idx_raddr_o  (idx_raddr),
    .idx_rdata_i  (idx_rdata),
    .feat_raddr_o (feat_raddr),
    .feat_rdata_i (feat_rdata),
    .wr_req_o     (wr_req),
    .wr_addr_o    (wr_addr),
    .wr_data_o    (wr_data)
  );

  h_bus_arbiter h_bus_arbiter_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_req_i    (wr_req),
    .wr_addr_i   (wr_addr),
    .wr_data_i   (wr_data),
    .rd_req_i    (rd_req_i),
    .rd_addr_i   (rd_addr_i),
    .rd_vld_o    (rd_vld_o),
    .rd_data_o   (rd_data_o),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_rdata_i (mem_rdata)
  );

endmodule

// File: tb/gat_scatter_asserts.sv
`timescale 1ns/1ps

module gat_scatter_asserts (
  input logic clk,
  input logic rst_n,
  input logic wr_req_i,
  input logic rd_req_i,
  input logic rd_vld_o
);

  // Count of failed assertions
  int assert_errs = 0;

  // Set by a host request, cleared once its data returns
  logic rd_open_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_open_q <= 1'b0;
    end else if (rd_req_i) begin
      rd_open_q <= 1'b1;
    end else if (rd_vld_o) begin
      rd_open_q <= 1'b0;
    end
  end

  // A pending read takes the first cycle free of handler writes
  a_read_granted: assert property (@(posedge clk) disable iff (!rst_n)
    rd_req_i ##1 !wr_req_i |=> rd_vld_o)
    else begin
      $error("host read not served in a cycle free of handler writes");
      assert_errs++;
    end

  a_vld_single: assert property (@(posedge clk) disable iff (!rst_n)
    rd_vld_o |=> !rd_vld_o)
    else begin
      $error("rd_vld_o held for two cycles");
      assert_errs++;
    end

  a_vld_after_req: assert property (@(posedge clk) disable iff (!rst_n)
    rd_vld_o |-> rd_open_q)
    else begin
      $error("rd_vld_o without an open host read");
      assert_errs++;
    end

endmodule

bind h_bus_arbiter gat_scatter_asserts asserts_i (
  .clk      (clk),
  .rst_n    (rst_n),
  .wr_req_i (wr_req_i),
  .rd_req_i (rd_req_i),
  .rd_vld_o (rd_vld_o)
);

// File: tb/tb_gat_scatter.sv
`timescale 1ns/1ps

module tb_gat_scatter;

  localparam int NFO    = gat_dims_pkg::NUM_FEATURE_OUT;
  localparam int NODES  = gat_dims_pkg::TOTAL_NODES;
  localparam int FEAT_D = gat_dims_pkg::FEAT_DEPTH;
  localparam int H_D    = gat_dims_pkg::H_DEPTH;

  // Worst case per run, every entry starting a subgraph
  localparam int RUN_CYCLES = NODES * (2 + 1 + 2 * NFO) + 4;
  localparam int READ_LIMIT = 4 * NFO + 8;
  localparam int NUM_RUNS   = 6;
  localparam int RUN_BUDGET = RUN_CYCLES + 4 * H_D + FEAT_D + NODES + 8;
  localparam int WDOG_CYCLES = NUM_RUNS * RUN_BUDGET + 100;

  logic                                 clk;
  logic                                 rst_n;
  logic                                 start_i;
  logic                                 busy_o;
  logic                                 done_o;
  logic                                 feat_we_i;
  logic [gat_dims_pkg::FEAT_ADDR_W-1:0] feat_waddr_i;
  gat_mem_pkg::feat_word_t              feat_wdata_i;
  logic                                 idx_we_i;
  logic [gat_dims_pkg::IDX_ADDR_W-1:0]  idx_waddr_i;
  gat_mem_pkg::idx_entry_t              idx_wdata_i;
  logic                                 rd_req_i;
  logic [gat_dims_pkg::H_ADDR_W-1:0]    rd_addr_i;
  logic                                 rd_vld_o;
  gat_mem_pkg::h_word_t                 rd_data_o;

  // Reference copies of the loaded memories and the expected H data
  gat_mem_pkg::feat_word_t feat_ref [FEAT_D];
  gat_mem_pkg::idx_entry_t idx_ref [NODES];
  gat_mem_pkg::h_word_t    h_exp [H_D];
  int                      errors;

  gat_scatter_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #(20ns) clk = ~clk;
  end

  initial begin
    repeat (WDOG_CYCLES) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles, %0d errors so far",
             WDOG_CYCLES, errors);
    $display("sim failed");
    $finish;
  end

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // Node n takes the vector of the last subgraph start at or before its entry
  function automatic void build_expected();
    int sg;
    int base;
    sg = -1;
    for (int e = 0; e < NODES; e++) begin
      if (idx_ref[e].sog) begin
        sg++;
      end
      base = int'(idx_ref[e].node_idx) * NFO;
      for (int k = 0; k < NFO; k++) begin
        h_exp[base + k].col = gat_dims_pkg::FEAT_IDX_W'(k);
        h_exp[base + k].val =
          feat_ref[sg * NFO + k][gat_mem_pkg::QUANT_SHIFT +: gat_mem_pkg::DATA_W];
      end
    end
  endfunction

  // Entry e takes nibble e of nodes and bit e of sog_mask
  function automatic void set_table(input logic [NODES-1:0] sog_mask, input logic [31:0] nodes);
    for (int e = 0; e < NODES; e++) begin
      idx_ref[e].sog      = sog_mask[e];
      idx_ref[e].node_idx = gat_dims_pkg::NODE_IDX_W'(nodes[4*e +: 4]);
    end
  endfunction

  task automatic load_features();
    for (int i = 0; i < FEAT_D; i++) begin
      feat_ref[i] = $urandom;
      @(posedge clk);
      feat_we_i    <= 1'b1;
      feat_waddr_i <= gat_dims_pkg::FEAT_ADDR_W'(i);
      feat_wdata_i <= feat_ref[i];
    end
    @(posedge clk);
    feat_we_i <= 1'b0;
  endtask

  task automatic load_table();
    for (int i = 0; i < NODES; i++) begin
      @(posedge clk);
      idx_we_i    <= 1'b1;
      idx_waddr_i <= gat_dims_pkg::IDX_ADDR_W'(i);
      idx_wdata_i <= idx_ref[i];
    end
    @(posedge clk);
    idx_we_i <= 1'b0;
  endtask

  task automatic pulse_start();
    @(posedge clk);
    start_i <= 1'b1;
    @(posedge clk);
    start_i <= 1'b0;
  endtask

  task automatic wait_done();
    int waited;
    waited = 0;
    @(negedge clk);
    while (!done_o && waited < RUN_CYCLES + 20) begin
      @(negedge clk);
      waited++;
    end
    if (!done_o) begin
      $display("done_o never arrived after start_i at %0t", $time);
      errors++;
    end
  endtask

  task automatic host_read(input int addr, output gat_mem_pkg::h_word_t data);
    int waited;
    waited = 0;
    data   = 'x;
    @(posedge clk);
    rd_req_i  <= 1'b1;
    rd_addr_i <= gat_dims_pkg::H_ADDR_W'(addr);
    @(posedge clk);
    rd_req_i <= 1'b0;
    @(negedge clk);
    while (!rd_vld_o && waited < READ_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (rd_vld_o) begin
      data = rd_data_o;
    end else begin
      $display("host read of address %0d got no rd_vld_o at %0t", addr, $time);
      errors++;
    end
  endtask

  task automatic read_all(input string tag);
    gat_mem_pkg::h_word_t got;
    for (int a = 0; a < H_D; a++) begin
      host_read(a, got);
      check_eq($sformatf("%s h[%0d]", tag, a), got, h_exp[a]);
    end
  endtask

  task automatic test_reset_state();
    @(negedge clk);
    check_eq("busy_o", busy_o, 1'b0);
    check_eq("done_o", done_o, 1'b0);
    check_eq("rd_vld_o", rd_vld_o, 1'b0);
  endtask

  task automatic test_run(input string tag, input logic [NODES-1:0] sog_mask,
                          input logic [31:0] nodes);
    load_features();
    set_table(sog_mask, nodes);
    load_table();
    build_expected();
    pulse_start();
    wait_done();
    read_all(tag);
  endtask

  task automatic test_start_while_busy();
    int extra;
    extra = 0;
    load_features();
    build_expected();
    pulse_start();
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_eq("busy_o before second start", busy_o, 1'b1);
    pulse_start();
    wait_done();
    repeat (RUN_CYCLES) begin
      @(negedge clk);
      if (done_o) begin
        extra++;
      end
    end
    check_eq("extra done_o pulses", extra, 0);
    check_eq("busy_o after run", busy_o, 1'b0);
    read_all("busy start");
  endtask

  // Same data again, so every word holds its value for the whole run
  task automatic test_reads_during_run();
    gat_mem_pkg::h_word_t got;
    int                   addr;
    fork
      begin
        pulse_start();
        wait_done();
      end
      begin
        @(negedge clk);
        while (!busy_o) @(negedge clk);
        for (int r = 0; r < 12; r++) begin
          addr = $urandom_range(H_D - 1);
          host_read(addr, got);
          check_eq($sformatf("busy read h[%0d]", addr), got, h_exp[addr]);
        end
      end
    join
    test_run("overwrite", 8'b1001_0001, 32'h0123_4567);
  endtask

  initial begin
    rst_n        = 1'b0;
    start_i      = 1'b0;
    feat_we_i    = 1'b0;
    feat_waddr_i = '0;
    feat_wdata_i = '0;
    idx_we_i     = 1'b0;
    idx_waddr_i  = '0;
    idx_wdata_i  = '0;
    rd_req_i     = 1'b0;
    rd_addr_i    = '0;
    errors       = 0;
    void'($urandom(18));
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    test_reset_state();
    // Subgraphs of 3, 2 and 3 nodes in order
    test_run("basic", 8'b0010_1001, 32'h7654_3210);
    test_run("permuted", 8'b0100_0101, 32'h4163_0725);
    test_start_while_busy();
    test_reads_during_run();

    errors += dut_i.h_bus_arbiter_i.asserts_i.assert_errs;
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: gat_scatter.f
common/gat_dims_pkg.sv
common/gat_mem_pkg.sv
src/bram_sdp.sv
subgraph_handler/subgraph_handler.sv
src/h_bus_arbiter.sv
src/gat_scatter_top.sv
tb/gat_scatter_asserts.sv
tb/tb_gat_scatter.sv
